// File: logic/lsuPkg.sv
package lsuPkg;

  // data and address share one width.
  typedef logic [31:0] dataWord;
  typedef logic [31:0] instNumT;
  typedef logic [7:0]  physRegT;
  typedef logic [2:0]  func3T;
  typedef logic [3:0]  byteEnT;
  typedef logic [4:0]  queueIdxT;

  localparam int queueDepth = 32;
  localparam int memWords   = 256; // word index is address bits 9:2.

  // risc-v funct3 size codes for loads and stores.
  localparam func3T funcByte  = 3'b000;
  localparam func3T funcHalf  = 3'b001;
  localparam func3T funcWord  = 3'b010;
  localparam func3T funcByteU = 3'b100;
  localparam func3T funcHalfU = 3'b101;

endpackage

// File: logic/addressGen.sv
`timescale 1ns/1ps

module addressGen (
  input  logic             clk,
  input  logic             reset,
  input  logic             issueValid,
  input  logic             issueStore,
  input  lsuPkg::instNumT  issueInstNum,
  input  lsuPkg::physRegT  issuePhy,
  input  lsuPkg::func3T    issueFunc3,
  input  lsuPkg::dataWord  issueBase,
  input  lsuPkg::dataWord  issueOffset,
  input  lsuPkg::dataWord  issueStoreData,
  output logic             lsOn,
  output logic             lsStore,
  output lsuPkg::instNumT  lsInstNum,
  output lsuPkg::physRegT  lsPhy,
  output lsuPkg::func3T    lsFunc3,
  output lsuPkg::dataWord  lsAddress,
  output lsuPkg::dataWord  lsStoreData
);

  always_ff @(posedge clk) begin
    if (reset) begin
      lsOn <= 1'b0;
    end else begin
      lsOn <= issueValid; // one cycle behind the issue.
    end
  end

  always_ff @(posedge clk) begin
    lsStore     <= issueStore;
    lsInstNum   <= issueInstNum;
    lsPhy       <= issuePhy;
    lsFunc3     <= issueFunc3;
    lsAddress   <= issueBase + issueOffset; // effective address.
    lsStoreData <= issueStoreData;
  end

endmodule

// File: logic/lsQueue.sv
`timescale 1ns/1ps

module lsQueue (
  input  logic             clk,
  input  logic             reset,
  input  logic             memStall,
  input  logic             lsOn,
  input  logic             lsStore,
  input  lsuPkg::instNumT  lsInstNum,
  input  lsuPkg::physRegT  lsPhy,
  input  lsuPkg::func3T    lsFunc3,
  input  lsuPkg::dataWord  lsAddress,
  input  lsuPkg::dataWord  lsStoreData,
  output logic             headValid,
  output logic             headStore,
  output lsuPkg::instNumT  headInstNum,
  output lsuPkg::physRegT  headPhy,
  output lsuPkg::func3T    headFunc3,
  output lsuPkg::dataWord  headAddress,
  output lsuPkg::dataWord  headStoreData,
  output logic             headHazard,
  output logic             retire,
  output logic             queueFull
);

  logic [lsuPkg::queueDepth-1:0] validQ;
  logic                          storeQ [lsuPkg::queueDepth];
  lsuPkg::instNumT               instQ  [lsuPkg::queueDepth];
  lsuPkg::physRegT               phyQ   [lsuPkg::queueDepth];
  lsuPkg::func3T                 func3Q [lsuPkg::queueDepth];
  lsuPkg::dataWord               addrQ  [lsuPkg::queueDepth];
  lsuPkg::dataWord               dataQ  [lsuPkg::queueDepth];
  lsuPkg::queueIdxT              head;
  lsuPkg::queueIdxT              tail;
  logic                          enqueue;

  assign headValid = validQ[head];
  assign retire    = headValid & ~memStall;
  // tail catches up with a live head only when all entries are in use.
  assign queueFull = validQ[tail];
  assign enqueue   = lsOn & ~queueFull; // dropped when full.

  always_ff @(posedge clk) begin
    if (reset) begin
      validQ <= '0;
      head   <= '0;
      tail   <= '0;
    end else begin
      if (retire) begin
        validQ[head] <= 1'b0;
        head         <= head + 1'b1; // wraps at depth.
      end
      if (enqueue) begin
        validQ[tail] <= 1'b1;
        tail         <= tail + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (enqueue) begin
      storeQ[tail] <= lsStore;
      instQ[tail]  <= lsInstNum;
      phyQ[tail]   <= lsPhy;
      func3Q[tail] <= lsFunc3;
      addrQ[tail]  <= lsAddress;
      dataQ[tail]  <= lsStoreData;
    end
  end

  // younger live entry on the same word with the other kind.
  always_comb begin
    headHazard = 1'b0;
    for (int i = 0; i < lsuPkg::queueDepth; i++) begin
      if (validQ[i] && (lsuPkg::queueIdxT'(i) != head) &&
          (addrQ[i][31:2] == addrQ[head][31:2]) &&
          (storeQ[i] != storeQ[head])) begin
        headHazard = 1'b1;
      end
    end
  end

  assign headStore     = storeQ[head];
  assign headInstNum   = instQ[head];
  assign headPhy       = phyQ[head];
  assign headFunc3     = func3Q[head];
  assign headAddress   = addrQ[head];
  assign headStoreData = dataQ[head];

endmodule

// File: logic/storeLaneMux.sv
`timescale 1ns/1ps

module storeLaneMux (
  input  lsuPkg::func3T    headFunc3,
  input  lsuPkg::dataWord  headAddress,
  input  lsuPkg::dataWord  headStoreData,
  output lsuPkg::byteEnT   byteEn,
  output lsuPkg::dataWord  laneData
);

  // move the low bytes up to the addressed lane.
  assign laneData = headStoreData << {headAddress[1:0], 3'b000};

  always_comb begin
    case (headFunc3)
      lsuPkg::funcByte: begin
        byteEn = 4'b0001 << headAddress[1:0];
      end
      lsuPkg::funcHalf: begin
        byteEn = 4'b0011 << {headAddress[1], 1'b0}; // lower or upper half.
      end
      lsuPkg::funcWord: begin
        byteEn = 4'b1111;
      end
      default: begin
        byteEn = 4'b0000; // not a store size.
      end
    endcase
  end

endmodule

// File: logic/dataMemory.sv
`timescale 1ns/1ps

module dataMemory (
  input  logic             clk,
  input  logic             writeEn,
  input  logic             readEn,
  input  logic [7:0]       wordAddr,
  input  lsuPkg::byteEnT   byteEn,
  input  lsuPkg::dataWord  laneData,
  output lsuPkg::dataWord  readWord
);

  lsuPkg::dataWord mem [lsuPkg::memWords];

  always_ff @(posedge clk) begin
    if (writeEn) begin
      for (int lane = 0; lane < 4; lane++) begin
        if (byteEn[lane]) begin
          mem[wordAddr][lane*8 +: 8] <= laneData[lane*8 +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (readEn) begin
      readWord <= mem[wordAddr]; // one cycle read.
    end
  end

endmodule

// File: logic/loadExtract.sv
`timescale 1ns/1ps

module loadExtract (
  input  logic             clk,
  input  logic             reset,
  input  logic             loadRetire,
  input  lsuPkg::func3T    headFunc3,
  input  lsuPkg::dataWord  headAddress,
  input  lsuPkg::physRegT  headPhy,
  input  lsuPkg::dataWord  readWord,
  output logic             wbValid,
  output lsuPkg::physRegT  wbPhy,
  output lsuPkg::dataWord  wbData
);

  logic            pendValid;
  lsuPkg::func3T   func3Q;
  logic [1:0]      offsetQ;
  lsuPkg::physRegT phyQ;
  lsuPkg::dataWord shifted;

  always_ff @(posedge clk) begin
    if (reset) begin
      pendValid <= 1'b0;
    end else begin
      pendValid <= loadRetire;
    end
  end

  // held until the read word is back.
  always_ff @(posedge clk) begin
    if (loadRetire) begin
      func3Q  <= headFunc3;
      offsetQ <= headAddress[1:0];
      phyQ    <= headPhy;
    end
  end

  assign shifted = readWord >> {offsetQ, 3'b000}; // addressed lane to bit 0.

  always_comb begin
    case (func3Q)
      lsuPkg::funcByte:  wbData = {{24{shifted[7]}}, shifted[7:0]};
      lsuPkg::funcHalf:  wbData = {{16{shifted[15]}}, shifted[15:0]};
      lsuPkg::funcByteU: wbData = {24'b0, shifted[7:0]};
      lsuPkg::funcHalfU: wbData = {16'b0, shifted[15:0]};
      lsuPkg::funcWord:  wbData = readWord;
      default:           wbData = readWord;
    endcase
  end

  assign wbValid = pendValid;
  assign wbPhy   = phyQ;

endmodule

// File: logic/lsuTop.sv
`timescale 1ns/1ps

module lsuTop (
  input  logic             clk,
  input  logic             reset,
  input  logic             issueValid,
  input  logic             issueStore,
  input  lsuPkg::instNumT  issueInstNum,
  input  lsuPkg::physRegT  issuePhy,
  input  lsuPkg::func3T    issueFunc3,
  input  lsuPkg::dataWord  issueBase,
  input  lsuPkg::dataWord  issueOffset,
  input  lsuPkg::dataWord  issueStoreData,
  input  logic             memStall,
  output logic             retireValid,
  output lsuPkg::instNumT  retireInstNum,
  output logic             retireHazard,
  output logic             wbValid,
  output lsuPkg::physRegT  wbPhy,
  output lsuPkg::dataWord  wbData,
  output logic             queueFull
);

  logic            lsOn;
  logic            lsStore;
  lsuPkg::instNumT lsInstNum;
  lsuPkg::physRegT lsPhy;
  lsuPkg::func3T   lsFunc3;
  lsuPkg::dataWord lsAddress;
  lsuPkg::dataWord lsStoreData;
  logic            headValid;
  logic            headStore;
  lsuPkg::instNumT headInstNum;
  lsuPkg::physRegT headPhy;
  lsuPkg::func3T   headFunc3;
  lsuPkg::dataWord headAddress;
  lsuPkg::dataWord headStoreData;
  logic            headHazard;
  logic            retire;
  lsuPkg::byteEnT  byteEn;
  lsuPkg::dataWord laneData;
  lsuPkg::dataWord readWord;
  logic            storeRetire;
  logic            loadRetire;

  assign storeRetire   = retire & headStore;
  assign loadRetire    = retire & ~headStore;
  assign retireValid   = retire;
  assign retireInstNum = retire ? headInstNum : '0;
  assign retireHazard  = retire & headValid & headHazard;

  addressGen u_addressGen (
    .clk(clk), .reset(reset),
    .issueValid(issueValid), .issueStore(issueStore), .issueInstNum(issueInstNum),
    .issuePhy(issuePhy), .issueFunc3(issueFunc3), .issueBase(issueBase),
    .issueOffset(issueOffset), .issueStoreData(issueStoreData),
    .lsOn(lsOn), .lsStore(lsStore), .lsInstNum(lsInstNum), .lsPhy(lsPhy),
    .lsFunc3(lsFunc3), .lsAddress(lsAddress), .lsStoreData(lsStoreData)
  );

  lsQueue u_lsQueue (
    .clk(clk), .reset(reset), .memStall(memStall),
    .lsOn(lsOn), .lsStore(lsStore), .lsInstNum(lsInstNum), .lsPhy(lsPhy),
    .lsFunc3(lsFunc3), .lsAddress(lsAddress), .lsStoreData(lsStoreData),
    .headValid(headValid), .headStore(headStore), .headInstNum(headInstNum),
    .headPhy(headPhy), .headFunc3(headFunc3), .headAddress(headAddress),
    .headStoreData(headStoreData), .headHazard(headHazard),
    .retire(retire), .queueFull(queueFull)
  );

  storeLaneMux u_storeLaneMux (
    .headFunc3(headFunc3), .headAddress(headAddress), .headStoreData(headStoreData),
    .byteEn(byteEn), .laneData(laneData)
  );

  dataMemory u_dataMemory (
    .clk(clk), .writeEn(storeRetire), .readEn(loadRetire),
    .wordAddr(headAddress[9:2]), .byteEn(byteEn), .laneData(laneData),
    .readWord(readWord)
  );

  loadExtract u_loadExtract (
    .clk(clk), .reset(reset), .loadRetire(loadRetire),
    .headFunc3(headFunc3), .headAddress(headAddress), .headPhy(headPhy),
    .readWord(readWord), .wbValid(wbValid), .wbPhy(wbPhy), .wbData(wbData)
  );

endmodule

// File: dv/lsuModel.svh
typedef struct {
  logic            store;
  lsuPkg::instNumT instNum;
  lsuPkg::physRegT phy;
  lsuPkg::func3T   func3;
  lsuPkg::dataWord addr;
  lsuPkg::dataWord data;
} expEntry;

typedef struct {
  lsuPkg::physRegT phy;
  lsuPkg::dataWord data;
} wbEntry;

expEntry         expQ[$];  // live queue entries in age order.
wbEntry          wbExp[$];
lsuPkg::dataWord modelMem [lsuPkg::memWords];
lsuPkg::dataWord lfsrState = 32'd34;

// galois lfsr stepped once per returned bit.
function automatic lsuPkg::dataWord randBits(int n);
  lsuPkg::dataWord r;
  r = '0;
  for (int k = 0; k < n; k++) begin
    r = {r[30:0], lfsrState[0]};
    lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h8020_0003) : (lfsrState >> 1);
  end
  return r;
endfunction

function automatic lsuPkg::dataWord extractLoad(lsuPkg::dataWord word, lsuPkg::func3T f3,
                                               logic [1:0] off);
  logic [7:0]  b;
  logic [15:0] h;
  b = word[off * 8 +: 8];
  h = word[off[1] * 16 +: 16];
  case (f3)
    lsuPkg::funcByte:  return {{24{b[7]}}, b};
    lsuPkg::funcHalf:  return {{16{h[15]}}, h};
    lsuPkg::funcByteU: return {24'b0, b};
    lsuPkg::funcHalfU: return {16'b0, h};
    default:           return word;
  endcase
endfunction

function automatic void applyStore(expEntry e);
  logic [7:0] w;
  w = e.addr[9:2];
  case (e.func3)
    lsuPkg::funcByte: modelMem[w][e.addr[1:0] * 8 +: 8] = e.data[7:0];
    lsuPkg::funcHalf: modelMem[w][e.addr[1] * 16 +: 16] = e.data[15:0];
    lsuPkg::funcWord: modelMem[w] = e.data;
    default: ;
  endcase
endfunction

// any other live entry on the same word with the other kind.
function automatic logic hazardFor();
  logic hit;
  hit = 1'b0;
  for (int i = 1; i < expQ.size(); i++) begin
    if (expQ[i].addr[31:2] == expQ[0].addr[31:2] && expQ[i].store != expQ[0].store) begin
      hit = 1'b1;
    end
  end
  return hit;
endfunction

// File: dv/lsuTb.sv
`timescale 1ns/1ps

module lsuTb;

  localparam int clkPeriod   = 10;
  localparam int resetCycles = 16;
  localparam int initWords   = 16;
  localparam int sizeRounds  = 8;
  localparam int mixCount    = 60;
  localparam int fillStall   = 40;
  localparam int resetIssues = 5;
  localparam int issueTotal  = initWords + sizeRounds * 6 + mixCount + 2 * lsuPkg::queueDepth
                               + 5 + resetIssues;
  localparam int stallTotal  = fillStall + 12 + lsuPkg::queueDepth + 6 + resetCycles + 10;
  localparam int watchdogCycles = 20 * issueTotal + stallTotal + 2 * resetCycles;

  logic            clk;
  logic            reset;
  logic            issueValid;
  logic            issueStore;
  lsuPkg::instNumT issueInstNum;
  lsuPkg::physRegT issuePhy;
  lsuPkg::func3T   issueFunc3;
  lsuPkg::dataWord issueBase;
  lsuPkg::dataWord issueOffset;
  lsuPkg::dataWord issueStoreData;
  logic            memStall;
  logic            retireValid;
  lsuPkg::instNumT retireInstNum;
  logic            retireHazard;
  logic            wbValid;
  lsuPkg::physRegT wbPhy;
  lsuPkg::dataWord wbData;
  logic            queueFull;

  `include "lsuModel.svh"

  lsuPkg::func3T   loadCodes [5] = '{lsuPkg::funcByte, lsuPkg::funcHalf, lsuPkg::funcWord,
                                     lsuPkg::funcByteU, lsuPkg::funcHalfU};
  lsuPkg::instNumT instCount;
  expEntry         stage;      // issue held in the address stage.
  logic            stageOn;

  lsuTop u_lsuTop (
    .clk(clk), .reset(reset), .issueValid(issueValid), .issueStore(issueStore),
    .issueInstNum(issueInstNum), .issuePhy(issuePhy), .issueFunc3(issueFunc3),
    .issueBase(issueBase), .issueOffset(issueOffset), .issueStoreData(issueStoreData),
    .memStall(memStall), .retireValid(retireValid), .retireInstNum(retireInstNum),
    .retireHazard(retireHazard), .wbValid(wbValid), .wbPhy(wbPhy), .wbData(wbData),
    .queueFull(queueFull)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  initial begin
    #(clkPeriod * watchdogCycles);
    stopOnError("timeout: retires stopped arriving before the test sequence ended");
  end

  task automatic stopOnError(string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic checkInstNum(string name, lsuPkg::instNumT got, lsuPkg::instNumT exp);
    if (got !== exp) stopOnError($sformatf("mismatch %0t %s: got %h expected %h",
                                           $time, name, got, exp));
  endtask

  task automatic checkPhy(string name, lsuPkg::physRegT got, lsuPkg::physRegT exp);
    if (got !== exp) stopOnError($sformatf("mismatch %0t %s: got %h expected %h",
                                           $time, name, got, exp));
  endtask

  task automatic checkData(string name, lsuPkg::dataWord got, lsuPkg::dataWord exp);
    if (got !== exp) stopOnError($sformatf("mismatch %0t %s: got %h expected %h",
                                           $time, name, got, exp));
  endtask

  task automatic checkFlag(string name, logic got, logic exp);
    if (got !== exp) stopOnError($sformatf("mismatch %0t %s: got %b expected %b",
                                           $time, name, got, exp));
  endtask

  // outputs are stable at the falling edge.
  always @(negedge clk) begin : compareOutputs
    expEntry head;
    wbEntry  wb;
    logic    wasFull;
    logic    expRetire;
    logic    expHazard;
    if (reset) begin
      expQ.delete();
      wbExp.delete();
      stageOn = 1'b0;
    end else begin
      checkFlag("wbValid", wbValid, wbExp.size() != 0);
      if (wbExp.size() != 0) begin
        wb = wbExp.pop_front();
        checkPhy("wbPhy", wbPhy, wb.phy);
        checkData("wbData", wbData, wb.data);
      end
      wasFull = (expQ.size() == lsuPkg::queueDepth);
      expRetire = (expQ.size() != 0) && !memStall;
      checkFlag("queueFull", queueFull, wasFull);
      checkFlag("retireValid", retireValid, expRetire);
      if (expRetire) begin
        head = expQ.pop_front();
        checkInstNum("retireInstNum", retireInstNum, head.instNum);
        expQ.push_front(head);
        expHazard = hazardFor();
        checkFlag("retireHazard", retireHazard, expHazard);
        if (head.store) begin
          applyStore(head);
        end else begin
          wb.phy = head.phy;
          wb.data = extractLoad(modelMem[head.addr[9:2]], head.func3, head.addr[1:0]);
          wbExp.push_back(wb);
        end
        void'(expQ.pop_front());
      end
      if (stageOn && !wasFull) expQ.push_back(stage); // enters the queue at the next edge.
      stageOn = issueValid;
      stage = '{issueStore, issueInstNum, issuePhy, issueFunc3, issueBase + issueOffset,
                issueStoreData};
    end
  end

  function automatic lsuPkg::dataWord randAddr(lsuPkg::func3T f3, logic [3:0] word);
    logic [1:0] low;
    low = 2'b00;
    if (f3 == lsuPkg::funcByte || f3 == lsuPkg::funcByteU) begin
      low = randBits(2);
    end else if (f3 == lsuPkg::funcHalf || f3 == lsuPkg::funcHalfU) begin
      low = randBits(1) << 1; // half aligned.
    end
    return {26'b0, word, low};
  endfunction

  task automatic issueOne(logic store, lsuPkg::func3T f3, lsuPkg::dataWord addr);
    lsuPkg::dataWord offset;
    @(posedge clk);
    #1;
    while (queueFull) begin
      issueValid = 1'b0;
      @(posedge clk);
      #1;
    end
    offset = randBits(6);
    issueValid = 1'b1;
    issueStore = store;
    issueInstNum = instCount;
    issuePhy = randBits(8);
    issueFunc3 = f3;
    issueBase = addr - offset;
    issueOffset = offset;
    issueStoreData = randBits(32);
    instCount++;
  endtask

  task automatic issueRandom();
    logic          store;
    lsuPkg::func3T f3;
    store = randBits(1);
    f3 = store ? loadCodes[randBits(2) % 3] : loadCodes[randBits(3) % 5];
    issueOne(store, f3, randAddr(f3, randBits(4)));
  endtask

  task automatic idleCycles(int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      issueValid = 1'b0;
    end
  endtask

  task automatic setStall(logic on);
    idleCycles(1);
    memStall = on;
  endtask

  task automatic holdReset();
    reset = 1'b1;
    issueValid = 1'b0;
    repeat (resetCycles) @(posedge clk);
    #1;
    reset = 1'b0;
  endtask

  task automatic drain();
    idleCycles(3);
    while (expQ.size() != 0 || wbExp.size() != 0 || stageOn) @(posedge clk);
  endtask

  initial begin
    logic [3:0]    word;
    lsuPkg::func3T f3;
    issueValid = 1'b0;
    issueStore = 1'b0;
    issueInstNum = '0;
    issuePhy = '0;
    issueFunc3 = '0;
    issueBase = '0;
    issueOffset = '0;
    issueStoreData = '0;
    memStall = 1'b0;
    instCount = '0;
    stageOn = 1'b0;
    holdReset();
    for (int w = 0; w < initWords; w++) begin
      issueOne(1'b1, lsuPkg::funcWord, w * 4); // every load hits a written word.
    end
    for (int r = 0; r < sizeRounds; r++) begin
      word = randBits(4);
      f3 = loadCodes[randBits(2) % 3];
      issueOne(1'b1, f3, randAddr(f3, word));
      for (int c = 0; c < 5; c++) begin
        issueOne(1'b0, loadCodes[c], randAddr(loadCodes[c], word));
      end
    end
    drain();
    repeat (mixCount) issueRandom();
    drain();
    setStall(1'b1);
    repeat (lsuPkg::queueDepth) issueRandom();
    idleCycles(fillStall - lsuPkg::queueDepth - 1);
    setStall(1'b0);
    drain();
    setStall(1'b1);
    issueOne(1'b0, lsuPkg::funcWord, 32'h20); // load, then store on word 8.
    issueOne(1'b1, lsuPkg::funcWord, 32'h20);
    issueOne(1'b1, lsuPkg::funcHalf, 32'h22);
    issueOne(1'b0, lsuPkg::funcByte, 32'h30);
    issueOne(1'b1, lsuPkg::funcByte, 32'h35);
    idleCycles(4);
    setStall(1'b0);
    drain();
    setStall(1'b1);
    repeat (lsuPkg::queueDepth) issueRandom(); // queue is full when reset hits.
    idleCycles(4);
    holdReset();
    setStall(1'b0);
    idleCycles(10);
    repeat (resetIssues) issueRandom();
    drain();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: lsuPipe.f
+incdir+dv
logic/lsuPkg.sv
logic/addressGen.sv
logic/lsQueue.sv
logic/storeLaneMux.sv
logic/dataMemory.sv
logic/loadExtract.sv
logic/lsuTop.sv
dv/lsuTb.sv
